/* common/mem_stage_macros.svh */
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Data path width
`define XLEN 32

// Byte address width seen by the data memory
`define ADDR_W 10

// Number of 32-bit words in the data memory
`define DMEM_WORDS 256

// Cycles from accept to read response, also busy time after any accept
`define DMEM_LATENCY 2

`endif

/* common/mem_stage_pkg.sv */
`include "mem_stage_macros.svh"

package mem_stage_pkg;

    // Memory operation carried by each micro-op
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        logic [3:0]        tag;
        logic [`XLEN-1:0]  rs1;
        logic [`XLEN-1:0]  rs2;
        logic [`XLEN-1:0]  imm;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  result;  // Load data lands here
        mem_op_e           op;
    } uop_t;

    // Cache port request
    typedef struct packed {
        logic              write;
        logic [`ADDR_W-1:0] addr;
        logic [`XLEN-1:0]  wdata;
        logic [3:0]        mask;   // One bit per byte lane
    } mem_req_t;

    // Cache port response
    typedef struct packed {
        logic [`XLEN-1:0]  rdata;
    } mem_rsp_t;

endpackage

/* mem_stage/mem_op_decoder.sv */
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module mem_op_decoder import mem_stage_pkg::*; (
    input  mem_op_e          op_i,
    input  logic [1:0]       offset_i,
    input  logic [`XLEN-1:0] store_data_i,
    output logic             read_o,
    output logic             write_o,
    output logic [3:0]       mask_o,
    output logic [`XLEN-1:0] wdata_o
);

    always_comb begin
        read_o  = 1'b0;
        write_o = 1'b0;
        mask_o  = 4'b0000;
        case (op_i)
            LB, LBU, LH, LHU, LW: begin
                read_o = 1'b1;
            end
            SB: begin
                write_o = 1'b1;
                mask_o  = 4'b0001 << offset_i;
            end
            SH: begin
                write_o = 1'b1;
                mask_o  = 4'b0011 << offset_i;  // Offset 3 undefined
            end
            SW: begin
                write_o = 1'b1;
                mask_o  = 4'b1111;
            end
            default: begin
                read_o  = 1'b0;
                write_o = 1'b0;
            end
        endcase
    end

    // Move store data up to the addressed lanes
    assign wdata_o = store_data_i << {offset_i, 3'b000};

endmodule

/* mem_stage/data_bus_unit.sv */
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module data_bus_unit import mem_stage_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     req_valid_i,
    input  mem_req_t req_i,
    output logic     done_o,
    output mem_rsp_t rsp_o,
    output logic     port_req_valid_o,
    output mem_req_t port_req_o,
    input  logic     port_req_ready_i,
    input  logic     port_rsp_valid_i,
    input  mem_rsp_t port_rsp_i,
    output logic     port_rsp_ready_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RSP
    } state_e;

    state_e   state_r;
    state_e   state_ns;
    mem_req_t req_r;

    always_comb begin
        state_ns         = state_r;
        done_o           = 1'b0;
        port_req_valid_o = 1'b0;
        port_rsp_ready_o = 1'b0;
        case (state_r)
            IDLE: begin
                if (req_valid_i) begin
                    state_ns = REQ;
                end
            end
            REQ: begin
                port_req_valid_o = 1'b1;
                if (port_req_ready_i) begin
                    if (req_r.write) begin
                        done_o   = 1'b1;  // Store is finished once accepted
                        state_ns = IDLE;
                    end else begin
                        state_ns = RSP;
                    end
                end
            end
            RSP: begin
                port_rsp_ready_o = 1'b1;
                if (port_rsp_valid_i) begin
                    done_o   = 1'b1;
                    state_ns = IDLE;
                end
            end
            default: state_ns = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_ns;
        end
    end

    // Held until the port takes it
    always_ff @(posedge clk_i) begin
        if (state_r == IDLE && req_valid_i) begin
            req_r <= req_i;
        end
    end

    assign port_req_o = req_r;
    assign rsp_o      = port_rsp_i;

endmodule

/* mem_stage/mem_stage.sv */
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module mem_stage import mem_stage_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  uop_t     uop_i,
    output logic     stall_o,
    output uop_t     wb_uop_o,
    output logic     port_req_valid_o,
    output mem_req_t port_req_o,
    input  logic     port_req_ready_i,
    input  logic     port_rsp_valid_i,
    input  mem_rsp_t port_rsp_i,
    output logic     port_rsp_ready_o
);

    typedef enum logic {
        READY,
        BUSY
    } state_e;

    state_e           state_r;
    state_e           state_ns;
    logic [`XLEN-1:0] addr_w;
    logic             read_w;
    logic             write_w;
    logic [3:0]       mask_w;
    logic [`XLEN-1:0] wdata_w;
    logic             req_valid_w;
    mem_req_t         req_w;
    logic             done_w;
    mem_rsp_t         rsp_w;
    logic [`XLEN-1:0] shifted_w;
    uop_t             wb_ns;
    logic             wb_valid_r;
    uop_t             wb_uop_r;

    assign addr_w = uop_i.rs1 + uop_i.imm;

    mem_op_decoder u_decoder (
        .op_i         ( uop_i.op      ),
        .offset_i     ( addr_w[1:0]   ),
        .store_data_i ( uop_i.rs2     ),
        .read_o       ( read_w        ),
        .write_o      ( write_w       ),
        .mask_o       ( mask_w        ),
        .wdata_o      ( wdata_w       )
    );

    always_comb begin
        req_w.write = write_w;
        req_w.addr  = addr_w[`ADDR_W-1:0];
        req_w.wdata = wdata_w;
        req_w.mask  = mask_w;
    end

    data_bus_unit u_dbu (
        .clk_i            ( clk_i            ),
        .rstn_i           ( rstn_i           ),
        .req_valid_i      ( req_valid_w      ),
        .req_i            ( req_w            ),
        .done_o           ( done_w           ),
        .rsp_o            ( rsp_w            ),
        .port_req_valid_o ( port_req_valid_o ),
        .port_req_o       ( port_req_o       ),
        .port_req_ready_i ( port_req_ready_i ),
        .port_rsp_valid_i ( port_rsp_valid_i ),
        .port_rsp_i       ( port_rsp_i       ),
        .port_rsp_ready_o ( port_rsp_ready_o )
    );

    always_comb begin
        state_ns    = state_r;
        req_valid_w = 1'b0;
        stall_o     = 1'b0;
        case (state_r)
            READY: begin
                if (uop_i.valid && (read_w || write_w)) begin
                    req_valid_w = 1'b1;
                    stall_o     = 1'b1;
                    state_ns    = BUSY;
                end
            end
            BUSY: begin
                stall_o = !done_w;  // Released in the done cycle
                if (done_w) begin
                    state_ns = READY;
                end
            end
            default: state_ns = READY;
        endcase
    end

    // Byte or halfword lands at bit 0
    assign shifted_w = rsp_w.rdata >> {addr_w[1:0], 3'b000};

    always_comb begin
        wb_ns = uop_i;
        if (done_w && read_w) begin
            case (uop_i.op)
                LB:      wb_ns.result = {{24{shifted_w[7]}}, shifted_w[7:0]};
                LBU:     wb_ns.result = {24'b0, shifted_w[7:0]};
                LH:      wb_ns.result = {{16{shifted_w[15]}}, shifted_w[15:0]};
                LHU:     wb_ns.result = {16'b0, shifted_w[15:0]};
                default: wb_ns.result = rsp_w.rdata;  // LW
            endcase
        end
        wb_ns.valid = uop_i.valid && !stall_o;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r    <= READY;
            wb_valid_r <= 1'b0;
        end else begin
            state_r    <= state_ns;
            wb_valid_r <= wb_ns.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_uop_r <= wb_ns;
    end

    always_comb begin
        wb_uop_o       = wb_uop_r;
        wb_uop_o.valid = wb_valid_r;
    end

endmodule

/* rtl/data_mem.sv */
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module data_mem import mem_stage_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     req_valid_i,
    input  mem_req_t req_i,
    output logic     req_ready_o,
    output logic     rsp_valid_o,
    output mem_rsp_t rsp_o,
    input  logic     rsp_ready_i
);

    localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

    logic [`XLEN-1:0]   mem_r [`DMEM_WORDS];
    logic [CNT_W-1:0]   busy_cnt_r;
    logic               rd_pend_r;
    logic [`XLEN-1:0]   rdata_r;
    logic               accept_w;
    logic [`ADDR_W-3:0] idx_w;

    assign idx_w       = req_i.addr[`ADDR_W-1:2];  // Word index
    assign req_ready_o = (busy_cnt_r == '0) && !rd_pend_r;
    assign accept_w    = req_valid_i && req_ready_o;

    // Read data shows once the counter reaches its last busy cycle
    assign rsp_valid_o = rd_pend_r && (busy_cnt_r <= CNT_W'(1));
    assign rsp_o       = '{rdata: rdata_r};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_cnt_r <= '0;
            rd_pend_r  <= 1'b0;
        end else begin
            if (accept_w) begin
                busy_cnt_r <= CNT_W'(`DMEM_LATENCY);
            end else if (busy_cnt_r != '0) begin
                busy_cnt_r <= busy_cnt_r - 1'b1;
            end
            if (accept_w && !req_i.write) begin
                rd_pend_r <= 1'b1;
            end else if (rsp_valid_o && rsp_ready_i) begin
                rd_pend_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_w) begin
            if (req_i.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.mask[b]) begin
                        mem_r[idx_w][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_r <= mem_r[idx_w];
            end
        end
    end

endmodule

/* rtl/mem_top.sv */
`timescale 1ns/10ps

module mem_top import mem_stage_pkg::*; (
    input  logic clk_i,
    input  logic rstn_i,
    input  uop_t uop_i,
    output logic stall_o,
    output uop_t wb_uop_o
);

    logic     req_valid_w;
    mem_req_t req_w;
    logic     req_ready_w;
    logic     rsp_valid_w;
    mem_rsp_t rsp_w;
    logic     rsp_ready_w;

    mem_stage u_mem_stage (
        .clk_i            ( clk_i       ),
        .rstn_i           ( rstn_i      ),
        .uop_i            ( uop_i       ),
        .stall_o          ( stall_o     ),
        .wb_uop_o         ( wb_uop_o    ),
        .port_req_valid_o ( req_valid_w ),
        .port_req_o       ( req_w       ),
        .port_req_ready_i ( req_ready_w ),
        .port_rsp_valid_i ( rsp_valid_w ),
        .port_rsp_i       ( rsp_w       ),
        .port_rsp_ready_o ( rsp_ready_w )
    );

    // Stands in for the L1 data cache
    data_mem u_data_mem (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .req_valid_i ( req_valid_w ),
        .req_i       ( req_w       ),
        .req_ready_o ( req_ready_w ),
        .rsp_valid_o ( rsp_valid_w ),
        .rsp_o       ( rsp_w       ),
        .rsp_ready_i ( rsp_ready_w )
    );

endmodule

/* verification/tb_mem_top.sv */
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module tb_mem_top import mem_stage_pkg::*; ();

    logic        clk;
    logic        rstn;
    uop_t        uop;
    logic        stall;
    uop_t        wb_uop;
    logic [7:0]  ref_mem [0:(1 << `ADDR_W)-1];  // Byte-wide reference
    logic [31:0] lcg_state;
    logic [3:0]  tag_cnt;

    mem_top UUT (
        .clk_i    ( clk    ),
        .rstn_i   ( rstn   ),
        .uop_i    ( uop    ),
        .stall_o  ( stall  ),
        .wb_uop_o ( wb_uop )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic uop_t make_uop(input mem_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data);
        uop_t u;
        u.valid  = 1'b1;
        u.pc     = lcg_rand();
        u.tag    = tag_cnt;
        u.imm    = lcg_rand();
        u.rs1    = addr - u.imm;  // rs1 + imm lands on addr
        u.rs2    = data;
        u.rd     = 5'(lcg_rand());
        u.result = lcg_rand();
        u.op     = op;
        tag_cnt  = tag_cnt + 4'd1;
        return u;
    endfunction

    // Little-endian byte lanes, sign or zero extension by op
    function automatic uop_t expected_wb(input uop_t u);
        uop_t        e;
        logic [31:0] a;
        e = u;
        a = (u.rs1 + u.imm) & ((32'd1 << `ADDR_W) - 32'd1);
        case (u.op)
            LB:  e.result = {{24{ref_mem[a][7]}}, ref_mem[a]};
            LBU: e.result = {24'h0, ref_mem[a]};
            LH:  e.result = {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            LHU: e.result = {16'h0, ref_mem[a+1], ref_mem[a]};
            LW:  e.result = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
            default: e.result = u.result;
        endcase
        return e;
    endfunction

    task automatic update_ref(input uop_t u);
        logic [31:0] a;
        a = (u.rs1 + u.imm) & ((32'd1 << `ADDR_W) - 32'd1);
        case (u.op)
            SB: ref_mem[a] = u.rs2[7:0];
            SH: begin
                ref_mem[a]   = u.rs2[7:0];
                ref_mem[a+1] = u.rs2[15:8];
            end
            SW: begin
                for (int b = 0; b < 4; b++) begin
                    ref_mem[a+b] = u.rs2[8*b +: 8];
                end
            end
            default: ;
        endcase
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h exp %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_uop(input uop_t got, input uop_t exp);
        check_val("wb_uop_o.tag", 32'(got.tag), 32'(exp.tag));
        check_val("wb_uop_o.pc", got.pc, exp.pc);
        check_val("wb_uop_o.rs1", got.rs1, exp.rs1);
        check_val("wb_uop_o.rs2", got.rs2, exp.rs2);
        check_val("wb_uop_o.imm", got.imm, exp.imm);
        check_val("wb_uop_o.rd", 32'(got.rd), 32'(exp.rd));
        check_val("wb_uop_o.op", 32'(got.op), 32'(exp.op));
        check_val("wb_uop_o.result", got.result, exp.result);
    endtask

    // Upstream holds the micro-op while stall is high
    task automatic send_uop(input uop_t u, output logic saw_stall);
        logic taken;
        uop       = u;
        saw_stall = 1'b0;
        taken     = 1'b0;
        for (int n = 0; n < 50 && !taken; n++) begin
            @(negedge clk);
            if (stall) begin
                if (saw_stall) begin
                    check_val("wb_uop_o.valid", 32'(wb_uop.valid), 32'h0);
                end
                saw_stall = 1'b1;
            end else begin
                taken = 1'b1;  // Consumed on the coming edge
            end
            @(posedge clk);
            #1;
        end
        uop = '0;
        if (!taken) begin
            report_failure("Timeout: micro-op was never taken, stall_o stayed high");
        end
    endtask

    task automatic wait_wb(output uop_t got);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            if (wb_uop.valid) begin
                got  = wb_uop;
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
        if (!seen) begin
            report_failure("Timeout: wb_uop_o valid never went high");
        end
    endtask

    task automatic run_uop(input uop_t u);
        uop_t exp;
        uop_t got;
        logic saw_stall;
        exp = expected_wb(u);
        update_ref(u);
        send_uop(u, saw_stall);
        wait_wb(got);
        compare_uop(got, exp);
        check_val("stall_o during access", 32'(saw_stall), 32'(u.op != NONE));
    endtask

    task automatic reset_state();
        rstn = 1'b0;
        uop  = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_val("wb_uop_o.valid", 32'(wb_uop.valid), 32'h0);
        check_val("stall_o", 32'(stall), 32'h0);
        @(posedge clk);
        #1;
    endtask

    task automatic pass_through();
        for (int n = 0; n < 4; n++) begin
            run_uop(make_uop(NONE, lcg_rand(), lcg_rand()));
        end
    endtask

    task automatic word_round_trip();
        logic [31:0] addr;
        for (int n = 0; n < 4; n++) begin
            addr = lcg_rand() & 32'h3fc;
            run_uop(make_uop(SW, addr, lcg_rand()));
            run_uop(make_uop(LW, addr, 32'h0));
        end
    endtask

    task automatic sub_word_access();
        logic [31:0] base;
        base = lcg_rand() & 32'h1fc;
        run_uop(make_uop(SW, base, lcg_rand()));  // All four bytes known
        for (int k = 0; k < 4; k++) begin
            run_uop(make_uop(SB, base + 32'(k), lcg_rand()));
            run_uop(make_uop(LW, base, 32'h0));
        end
        for (int k = 0; k < 4; k++) begin
            run_uop(make_uop(LB, base + 32'(k), 32'h0));
            run_uop(make_uop(LBU, base + 32'(k), 32'h0));
        end
        for (int k = 0; k < 4; k += 2) begin
            run_uop(make_uop(SH, base + 32'(k), lcg_rand()));
            run_uop(make_uop(LW, base, 32'h0));
            run_uop(make_uop(LH, base + 32'(k), 32'h0));
            run_uop(make_uop(LHU, base + 32'(k), 32'h0));
        end
    endtask

    task automatic back_to_back_mix();
        logic [31:0] addr;
        mem_op_e     op;
        for (int n = 0; n < 8; n++) begin
            run_uop(make_uop(SW, 32'h200 + 32'(4*n), lcg_rand()));
        end
        for (int n = 0; n < 60; n++) begin
            op   = mem_op_e'(4'(lcg_rand() % 32'd9));
            addr = 32'h200 + (lcg_rand() & 32'h1f);
            case (op)
                LH, LHU, SH: addr[0] = 1'b0;
                LW, SW:      addr[1:0] = 2'b00;
                default: ;
            endcase
            run_uop(make_uop(op, addr, lcg_rand()));
        end
    endtask

    initial begin
        rstn      = 1'b0;
        uop       = '0;
        lcg_state = 32'hea3b37fe;
        tag_cnt   = 4'd0;
        reset_state();
        pass_through();
        word_round_trip();
        sub_word_access();
        back_to_back_mix();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/mem_stage_pkg.sv
mem_stage/mem_op_decoder.sv
mem_stage/data_bus_unit.sv
mem_stage/mem_stage.sv
rtl/data_mem.sv
rtl/mem_top.sv
verification/tb_mem_top.sv

/* Makefile */
TOP = tb_mem_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
